/* Makefile */
BIN  = obj_dir/Vfc_subsystem_tb
SRCS = $(shell cat fc_subsystem.f)

.PHONY: all run clean

all: run

$(BIN): fc_subsystem.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module fc_subsystem_tb -f fc_subsystem.f

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

/* common/fc_bus_pkg.sv */
/*
 * L2 bus and APB types of the fabric controller
 * APB offsets are byte offsets inside the 4 KiB controller window
 */
package fc_bus_pkg;

    // L2 side, one 32-bit word per transfer
    typedef logic [31:0] fc_addr_t;
    typedef logic [31:0] fc_data_t;
    typedef logic [3:0]  fc_be_t;

    // APB offset inside the controller window
    typedef logic [11:0] apb_addr_t;

    // Mask register and its set and clear aliases
    localparam apb_addr_t REG_MASK     = 12'h000;
    localparam apb_addr_t REG_MASK_SET = 12'h004;
    localparam apb_addr_t REG_MASK_CLR = 12'h008;

    // Pending register and its set and clear aliases
    localparam apb_addr_t REG_INT      = 12'h00C;
    localparam apb_addr_t REG_INT_SET  = 12'h010;
    localparam apb_addr_t REG_INT_CLR  = 12'h014;

    // Read returns the event FIFO head and pops it
    localparam apb_addr_t REG_FIFO     = 12'h024;

    // Bit 0 fetch enable, bit 1 clock enable
    localparam apb_addr_t REG_CTRL     = 12'h028;

endpackage

/* common/fc_irq_pkg.sv */
/*
 * Interrupt numbering of the fabric controller
 * 32 lines; the highest pending masked line wins
 */
package fc_irq_pkg;

    // Number of interrupt lines
    localparam int unsigned NUM_IRQ = 32;

    // Interrupt number as seen by the handler
    typedef logic [$clog2(NUM_IRQ)-1:0] irq_id_t;

    // One bit per interrupt line
    typedef logic [NUM_IRQ-1:0] irq_vec_t;

    // Pending while the event FIFO holds an entry
    localparam irq_id_t FIFO_IRQ = 5'd26;

endpackage

/* fc_core/fc_irq_handler.sv */
/*
 * Interrupt handler engine in place of the core
 * Per ID: read vector at boot base + 4*ID, then write the service count there
 * One transfer outstanding on each port; the data port only writes full words
 */
`timescale 1ns/1ps

module fc_irq_handler
    import fc_bus_pkg::*;
    import fc_irq_pkg::*;
#(
    parameter int unsigned ACK_FIFO_DEPTH = 4
) (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     enable_i,
    input  logic     clock_en_i,
    input  fc_addr_t boot_addr_i,
    // Interrupt handshake
    input  logic     core_irq_req_i,
    input  irq_id_t  core_irq_id_i,
    output logic     core_irq_ack_o,
    output irq_id_t  core_irq_ack_id_o,
    // Instruction port
    output logic     instr_req_o,
    output fc_addr_t instr_addr_o,
    input  logic     instr_gnt_i,
    input  logic     instr_rvalid_i,
    input  fc_data_t instr_rdata_i,
    // Data port
    output logic     data_req_o,
    output fc_addr_t data_addr_o,
    output logic     data_we_o,
    output fc_be_t   data_be_o,
    output fc_data_t data_wdata_o,
    input  logic     data_gnt_i,
    input  logic     data_rvalid_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_WRITE,
        ST_RESP
    } state_t;

    state_t   state_q;
    logic     fetch_gnt_q;
    irq_id_t  cur_id_q;
    fc_addr_t vector_q;
    fc_data_t count_q;
    logic     q_full;
    logic     q_empty;
    logic     q_pop;
    irq_id_t  q_head;
    logic     vec_done;

    // ********************************************************
    // Acknowledge and ID queue
    // ********************************************************
    assign core_irq_ack_o    = core_irq_req_i & enable_i & clock_en_i & ~q_full;
    assign core_irq_ack_id_o = core_irq_id_i;

    fc_fifo #(
        .payload_t ( irq_id_t       ),
        .DEPTH     ( ACK_FIFO_DEPTH )
    ) ack_fifo_i (
        .clk_i   ( clk_i          ),
        .reset_i ( reset_i        ),
        .push_i  ( core_irq_ack_o ),
        .data_i  ( core_irq_id_i  ),
        .pop_i   ( q_pop          ),
        .data_o  ( q_head         ),
        .full_o  ( q_full         ),
        .empty_o ( q_empty        )
    );

    // ********************************************************
    // Port sequence
    // ********************************************************
    assign q_pop    = (state_q == ST_IDLE) & ~q_empty;
    assign vec_done = (state_q == ST_FETCH) & fetch_gnt_q & instr_rvalid_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= ST_IDLE;
            fetch_gnt_q <= 1'b0;
            count_q     <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (q_pop) begin
                        state_q <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (instr_req_o && instr_gnt_i) begin
                        fetch_gnt_q <= 1'b1;
                    end
                    if (vec_done) begin
                        fetch_gnt_q <= 1'b0;
                        state_q     <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (data_gnt_i) begin
                        count_q <= data_wdata_o;
                        state_q <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (data_rvalid_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (q_pop) begin
            cur_id_q <= q_head;
        end
        if (vec_done) begin
            vector_q <= instr_rdata_i;
        end
    end

    // Vector table sits on the 256-byte aligned boot base
    assign instr_req_o  = (state_q == ST_FETCH) & ~fetch_gnt_q;
    assign instr_addr_o = {boot_addr_i[31:8], 8'h00} + fc_addr_t'({cur_id_q, 2'b00});

    assign data_req_o   = (state_q == ST_WRITE);
    assign data_addr_o  = vector_q;
    assign data_we_o    = 1'b1;
    assign data_be_o    = '1;
    assign data_wdata_o = count_q + 1'b1;

endmodule

/* fc_eu/fc_interrupt_cntrl.sv */
/*
 * Interrupt controller on APB, no wait states
 * FIFO_IRQ mirrors the event FIFO and is cleared only by popping through REG_FIFO
 * A register or event change shows on core_irq_req_o two cycles later
 */
`timescale 1ns/1ps

module fc_interrupt_cntrl
    import fc_bus_pkg::*;
    import fc_irq_pkg::*;
#(
    parameter int unsigned EVENT_ID_WIDTH = 8,
    parameter int unsigned EVT_FIFO_DEPTH = 4
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    // APB slave
    input  apb_addr_t                 paddr_i,
    input  logic                      pwrite_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  fc_data_t                  pwdata_i,
    output fc_data_t                  prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    // Event sources
    input  irq_vec_t                  events_i,
    input  logic                      event_fifo_valid_i,
    input  logic [EVENT_ID_WIDTH-1:0] event_fifo_data_i,
    output logic                      event_fifo_fulln_o,
    // Core side
    input  logic                      core_irq_ack_i,
    input  irq_id_t                   core_irq_ack_id_i,
    output logic                      core_irq_req_o,
    output irq_id_t                   core_irq_id_o,
    output logic                      core_clock_en_o,
    output logic                      fetch_en_o
);

    typedef logic [EVENT_ID_WIDTH-1:0] event_id_t;

    irq_vec_t   mask_q;
    irq_vec_t   pending_q;
    irq_vec_t   pending_d;
    irq_vec_t   int_view;
    irq_vec_t   active;
    irq_id_t    sel_id;
    logic [1:0] ctrl_q;
    logic       apb_wr;
    logic       apb_rd;
    logic       addr_ok;
    logic       fifo_rd;
    logic       fifo_full;
    logic       fifo_empty;
    event_id_t  fifo_head;

    // ********************************************************
    // Event FIFO
    // ********************************************************
    fc_fifo #(
        .payload_t ( event_id_t     ),
        .DEPTH     ( EVT_FIFO_DEPTH )
    ) evt_fifo_i (
        .clk_i   ( clk_i                  ),
        .reset_i ( reset_i                ),
        .push_i  ( event_fifo_valid_i     ),
        .data_i  ( event_fifo_data_i      ),
        .pop_i   ( fifo_rd & ~fifo_empty  ),
        .data_o  ( fifo_head              ),
        .full_o  ( fifo_full              ),
        .empty_o ( fifo_empty             )
    );

    assign event_fifo_fulln_o = ~fifo_full;

    // ********************************************************
    // APB access
    // ********************************************************
    assign apb_wr   = psel_i & penable_i & pwrite_i;
    assign apb_rd   = psel_i & penable_i & ~pwrite_i;
    assign fifo_rd  = apb_rd & (paddr_i == REG_FIFO);
    assign pready_o = 1'b1;

    // Pending word as software sees it
    always_comb begin
        int_view           = pending_q;
        int_view[FIFO_IRQ] = ~fifo_empty;
    end

    always_comb begin
        prdata_o = '0;
        addr_ok  = 1'b1;
        case (paddr_i)
            REG_MASK, REG_MASK_SET, REG_MASK_CLR: prdata_o = mask_q;
            REG_INT, REG_INT_SET, REG_INT_CLR:    prdata_o = int_view;
            REG_FIFO: prdata_o[EVENT_ID_WIDTH-1:0] = fifo_head;
            REG_CTRL: prdata_o[1:0] = ctrl_q;
            default:  addr_ok = 1'b0;
        endcase
    end

    assign pslverr_o = psel_i & penable_i & (~addr_ok | (fifo_rd & fifo_empty));

    // ********************************************************
    // Pending, mask and request
    // ********************************************************
    always_comb begin
        pending_d = pending_q;
        if (core_irq_ack_i) begin
            pending_d[core_irq_ack_id_i] = 1'b0;
        end
        if (apb_wr) begin
            case (paddr_i)
                REG_INT:     pending_d = pwdata_i;
                REG_INT_SET: pending_d = pending_d | pwdata_i;
                REG_INT_CLR: pending_d = pending_d & ~pwdata_i;
                default:     ;
            endcase
        end
        // A strobe held high keeps its line pending
        pending_d = pending_d | events_i;
    end

    assign active = int_view & mask_q;

    // Highest numbered line wins
    always_comb begin
        sel_id = '0;
        for (int i = 0; i < NUM_IRQ; i++) begin
            if (active[i]) begin
                sel_id = irq_id_t'(i);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mask_q         <= '0;
            pending_q      <= '0;
            ctrl_q         <= 2'b11;
            core_irq_req_o <= 1'b0;
            core_irq_id_o  <= '0;
        end else begin
            pending_q <= pending_d;
            if (apb_wr) begin
                case (paddr_i)
                    REG_MASK:     mask_q <= pwdata_i;
                    REG_MASK_SET: mask_q <= mask_q | pwdata_i;
                    REG_MASK_CLR: mask_q <= mask_q & ~pwdata_i;
                    REG_CTRL:     ctrl_q <= pwdata_i[1:0];
                    default:      ;
                endcase
            end
            // Drop the request for one cycle while the acked bit clears
            core_irq_req_o <= ~core_irq_ack_i & (|active);
            core_irq_id_o  <= sel_id;
        end
    end

    assign fetch_en_o      = ctrl_q[0];
    assign core_clock_en_o = ctrl_q[1];

endmodule

/* fc_subsystem.f */
common/fc_bus_pkg.sv
common/fc_irq_pkg.sv
hdl/fc_fifo.sv
fc_eu/fc_interrupt_cntrl.sv
fc_core/fc_irq_handler.sv
hdl/fc_subsystem.sv
verification/fc_subsystem_checker.sv
verification/fc_subsystem_tb.sv

/* hdl/fc_fifo.sv */
/*
 * Synchronous FIFO, first-word fall-through on data_o
 * Push while full and pop while empty are ignored
 */
`timescale 1ns/1ps

module fc_fifo #(
    parameter type         payload_t = logic [7:0],
    parameter int unsigned DEPTH     = 4
) (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     full_o,
    output logic     empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    payload_t             mem [DEPTH];
    logic [PTR_W-1:0]     wr_ptr_q;
    logic [PTR_W-1:0]     rd_ptr_q;
    logic [CNT_W-1:0]     count_q;
    logic                 do_push;
    logic                 do_pop;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;
    assign data_o  = mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

/* hdl/fc_subsystem.sv */
/*
 * Fabric controller: interrupt controller plus handler engine
 * Both L2 ports use req/gnt/rvalid with one transfer outstanding
 * Write responses on the data port carry no data
 */
`timescale 1ns/1ps

module fc_subsystem
    import fc_bus_pkg::*;
    import fc_irq_pkg::*;
#(
    parameter int unsigned EVENT_ID_WIDTH = 8,
    parameter int unsigned EVT_FIFO_DEPTH = 4,
    parameter int unsigned ACK_FIFO_DEPTH = 4
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      fetch_en_i,
    // APB slave of the controller
    input  apb_addr_t                 paddr_i,
    input  logic                      pwrite_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  fc_data_t                  pwdata_i,
    output fc_data_t                  prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    // Events
    input  irq_vec_t                  events_i,
    input  logic                      event_fifo_valid_i,
    input  logic [EVENT_ID_WIDTH-1:0] event_fifo_data_i,
    output logic                      event_fifo_fulln_o,
    // L2 instruction port
    output logic                      instr_req_o,
    output fc_addr_t                  instr_addr_o,
    input  logic                      instr_gnt_i,
    input  logic                      instr_rvalid_i,
    input  fc_data_t                  instr_rdata_i,
    // L2 data port
    output logic                      data_req_o,
    output fc_addr_t                  data_addr_o,
    output logic                      data_we_o,
    output fc_be_t                    data_be_o,
    output fc_data_t                  data_wdata_o,
    input  logic                      data_gnt_i,
    input  logic                      data_rvalid_i,
    input  fc_data_t                  data_rdata_i,
    input  fc_addr_t                  boot_addr_i
);

    logic    core_irq_req;
    irq_id_t core_irq_id;
    logic    core_irq_ack;
    irq_id_t core_irq_ack_id;
    logic    core_clock_en;
    logic    fetch_en_eu;
    logic    handler_en;

    // Both the pin and the controller bit must allow fetching
    assign handler_en = fetch_en_eu & fetch_en_i;

    // ********************************************************
    // Interrupt controller
    // ********************************************************
    fc_interrupt_cntrl #(
        .EVENT_ID_WIDTH ( EVENT_ID_WIDTH ),
        .EVT_FIFO_DEPTH ( EVT_FIFO_DEPTH )
    ) fc_eu_i (
        .clk_i              ( clk_i              ),
        .reset_i            ( reset_i            ),
        .paddr_i            ( paddr_i            ),
        .pwrite_i           ( pwrite_i           ),
        .psel_i             ( psel_i             ),
        .penable_i          ( penable_i          ),
        .pwdata_i           ( pwdata_i           ),
        .prdata_o           ( prdata_o           ),
        .pready_o           ( pready_o           ),
        .pslverr_o          ( pslverr_o          ),
        .events_i           ( events_i           ),
        .event_fifo_valid_i ( event_fifo_valid_i ),
        .event_fifo_data_i  ( event_fifo_data_i  ),
        .event_fifo_fulln_o ( event_fifo_fulln_o ),
        .core_irq_ack_i     ( core_irq_ack       ),
        .core_irq_ack_id_i  ( core_irq_ack_id    ),
        .core_irq_req_o     ( core_irq_req       ),
        .core_irq_id_o      ( core_irq_id        ),
        .core_clock_en_o    ( core_clock_en      ),
        .fetch_en_o         ( fetch_en_eu        )
    );

    // ********************************************************
    // Handler engine
    // ********************************************************
    fc_irq_handler #(
        .ACK_FIFO_DEPTH ( ACK_FIFO_DEPTH )
    ) fc_core_i (
        .clk_i             ( clk_i           ),
        .reset_i           ( reset_i         ),
        .enable_i          ( handler_en      ),
        .clock_en_i        ( core_clock_en   ),
        .boot_addr_i       ( boot_addr_i     ),
        .core_irq_req_i    ( core_irq_req    ),
        .core_irq_id_i     ( core_irq_id     ),
        .core_irq_ack_o    ( core_irq_ack    ),
        .core_irq_ack_id_o ( core_irq_ack_id ),
        .instr_req_o       ( instr_req_o     ),
        .instr_addr_o      ( instr_addr_o    ),
        .instr_gnt_i       ( instr_gnt_i     ),
        .instr_rvalid_i    ( instr_rvalid_i  ),
        .instr_rdata_i     ( instr_rdata_i   ),
        .data_req_o        ( data_req_o      ),
        .data_addr_o       ( data_addr_o     ),
        .data_we_o         ( data_we_o       ),
        .data_be_o         ( data_be_o       ),
        .data_wdata_o      ( data_wdata_o    ),
        .data_gnt_i        ( data_gnt_i      ),
        .data_rvalid_i     ( data_rvalid_i   )
    );

endmodule

/* verification/fc_subsystem_checker.sv */
/*
 * Protocol assertions bound into the fabric controller top level
 * Assumes one outstanding transfer per L2 port
 */
`timescale 1ns/1ps

module fc_subsystem_checker
    import fc_bus_pkg::*;
(
    input logic     clk_i,
    input logic     reset_i,
    input logic     instr_req_i,
    input fc_addr_t instr_addr_i,
    input logic     instr_gnt_i,
    input logic     instr_rvalid_i,
    input logic     data_req_i,
    input fc_addr_t data_addr_i,
    input fc_data_t data_wdata_i,
    input logic     data_gnt_i,
    input logic     data_rvalid_i,
    input logic     irq_req_i,
    input logic     irq_ack_i
);

    logic instr_busy_q;
    logic data_busy_q;

    // Outstanding transfer from grant until response
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            instr_busy_q <= 1'b0;
            data_busy_q  <= 1'b0;
        end else begin
            if (instr_req_i && instr_gnt_i) begin
                instr_busy_q <= 1'b1;
            end else if (instr_rvalid_i) begin
                instr_busy_q <= 1'b0;
            end
            if (data_req_i && data_gnt_i) begin
                data_busy_q <= 1'b1;
            end else if (data_rvalid_i) begin
                data_busy_q <= 1'b0;
            end
        end
    end

    // ********************************************************
    // L2 request stability and ordering
    // ********************************************************
    instr_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_req_i && !instr_gnt_i |=> instr_req_i && $stable(instr_addr_i))
        else $error("Instruction request changed before its grant");

    data_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
        data_req_i && !data_gnt_i |=>
            data_req_i && $stable(data_addr_i) && $stable(data_wdata_i))
        else $error("Data request changed before its grant");

    instr_single_a: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_busy_q |-> !instr_req_i)
        else $error("Second instruction request before the response");

    data_single_a: assert property (@(posedge clk_i) disable iff (reset_i)
        data_busy_q |-> !data_req_i)
        else $error("Second data request before the response");

    // Interrupt handshake
    ack_req_a: assert property (@(posedge clk_i) disable iff (reset_i)
        irq_ack_i |=> !irq_req_i)
        else $error("Interrupt request not dropped in the cycle after its acknowledge");

endmodule

bind fc_subsystem fc_subsystem_checker checker_i (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .instr_req_i    ( instr_req_o    ),
    .instr_addr_i   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .data_req_i     ( data_req_o     ),
    .data_addr_i    ( data_addr_o    ),
    .data_wdata_i   ( data_wdata_o   ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_rvalid_i  ( data_rvalid_i  ),
    .irq_req_i      ( core_irq_req   ),
    .irq_ack_i      ( core_irq_ack   )
);

/* verification/fc_subsystem_stimulus.txt */
# V id word loads a vector; W off data is an APB write; R off data err is an APB read
# E lines strobes events; P id fulln pushes an ID; F pin sets fetch_en_i; X addr expects a write
# N cycles expects no write; S addr cycles takes writes to addr until quiet
V 05 1C010000
V 09 1C010010
V 0C 1C010020
V 03 1C010030
V 1A 1C010040
V 07 1C010050
# Line 5 masked, then strobed
W 004 00000020
E 00000020
X 1C010000
R 00C 00000000 0
# Line 9 stays pending until its mask bit is set
E 00000200
N 20
R 00C 00000200 0
W 004 00000200
X 1C010010
# Lines 12 and 3 from one write, higher line first
W 004 00001008
W 010 00001008
X 1C010020
X 1C010030
# Event FIFO filled with the fetch pin low, fifth push dropped
F 0
W 004 04000000
P A1 1
P B2 1
P C3 1
P D4 0
P E5 0
N 20
R 00C 04000000 0
F 1
X 1C010040
R 024 000000A1 0
R 024 000000B2 0
R 024 000000C3 0
R 024 000000D4 0
S 1C010040 40
# Fetch enable bit in the control register
W 028 00000002
W 004 00000080
W 010 00000080
N 20
R 00C 00000080 0
R 028 00000002 0
W 028 00000003
X 1C010050
# Slave errors
R 024 00000000 1
R 030 00000000 1
R 00C 00000000 0
N 30

/* verification/fc_subsystem_tb.sv */
/*
 * Testbench for the fabric controller, run from the project root
 * Commands come from verification/fc_subsystem_stimulus.txt
 * L2 model grants after 0 to 3 cycles and answers one cycle after the grant
 */
`timescale 1ns/1ps

module fc_subsystem_tb
    import fc_bus_pkg::*;
    import fc_irq_pkg::*;
();

    localparam fc_addr_t BOOT_ADDR = 32'h1C00_8080;
    localparam int       TIMEOUT   = 300;

    logic                clk_i;
    logic                reset_i;
    logic                fetch_en_i;
    apb_addr_t           paddr_i;
    logic                pwrite_i;
    logic                psel_i;
    logic                penable_i;
    fc_data_t            pwdata_i;
    fc_data_t            prdata_o;
    logic                pready_o;
    logic                pslverr_o;
    irq_vec_t            events_i;
    logic                event_fifo_valid_i;
    logic [7:0]          event_fifo_data_i;
    logic                event_fifo_fulln_o;
    logic                instr_req_o;
    fc_addr_t            instr_addr_o;
    logic                instr_gnt_i;
    logic                instr_rvalid_i;
    fc_data_t            instr_rdata_i;
    logic                data_req_o;
    fc_addr_t            data_addr_o;
    logic                data_we_o;
    fc_be_t              data_be_o;
    fc_data_t            data_wdata_o;
    logic                data_gnt_i;
    logic                data_rvalid_i;
    fc_data_t            data_rdata_i;
    fc_addr_t            boot_addr_i;

    fc_data_t            vector_mem [fc_addr_t];
    fc_addr_t            wr_addr_q [$];
    fc_data_t            wr_data_q [$];
    fc_data_t            exp_count;

    fc_subsystem #(
        .EVENT_ID_WIDTH ( 8 ),
        .EVT_FIFO_DEPTH ( 4 ),
        .ACK_FIFO_DEPTH ( 4 )
    ) dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    // Unlisted addresses read a pattern built from the whole address
    function automatic fc_data_t vector_word(input fc_addr_t addr);
        if (vector_mem.exists(addr)) begin
            return vector_mem[addr];
        end
        return addr ^ 32'hA5C3_0F69;
    endfunction

    // ********************************************************
    // L2 memory model for both ports
    // ********************************************************
    initial begin
        int       instr_delay;
        int       data_delay;
        fc_addr_t instr_addr_hold;
        void'($urandom(32'h15ce));
        instr_delay    = -1;
        data_delay     = -1;
        instr_gnt_i    = 1'b0;
        instr_rvalid_i = 1'b0;
        instr_rdata_i  = '0;
        data_gnt_i     = 1'b0;
        data_rvalid_i  = 1'b0;
        data_rdata_i   = '0;
        forever begin
            @(negedge clk_i);
            instr_rvalid_i = 1'b0;
            data_rvalid_i  = 1'b0;
            if (instr_gnt_i) begin
                instr_gnt_i    = 1'b0;
                instr_rvalid_i = 1'b1;
                instr_rdata_i  = vector_word(instr_addr_hold);
            end else if (instr_req_o && !reset_i) begin
                if (instr_delay < 0) begin
                    instr_delay = int'($urandom % 4);
                end
                if (instr_delay == 0) begin
                    instr_gnt_i     = 1'b1;
                    instr_addr_hold = instr_addr_o;
                end
                instr_delay = instr_delay - 1;
            end
            if (data_gnt_i) begin
                data_gnt_i    = 1'b0;
                data_rvalid_i = 1'b1;
            end else if (data_req_o && !reset_i) begin
                if (data_delay < 0) begin
                    data_delay = int'($urandom % 4);
                end
                if (data_delay == 0) begin
                    check_value("data_we_o", 32'(data_we_o), 32'h1);
                    check_value("data_be_o", 32'(data_be_o), 32'hF);
                    data_gnt_i = 1'b1;
                    wr_addr_q.push_back(data_addr_o);
                    wr_data_q.push_back(data_wdata_o);
                end
                data_delay = data_delay - 1;
            end
        end
    end

    // ********************************************************
    // APB and event drivers
    // ********************************************************
    task automatic apb_write(input apb_addr_t off, input fc_data_t data);
        psel_i   = 1'b1;
        pwrite_i = 1'b1;
        paddr_i  = off;
        pwdata_i = data;
        @(negedge clk_i);
        penable_i = 1'b1;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    // Read data is only defined when no slave error is expected
    task automatic apb_read(input apb_addr_t off, input fc_data_t exp, input logic exp_err);
        psel_i   = 1'b1;
        pwrite_i = 1'b0;
        paddr_i  = off;
        @(negedge clk_i);
        penable_i = 1'b1;
        #1;
        check_value("pready_o", 32'(pready_o), 32'h1);
        check_value("pslverr_o", 32'(pslverr_o), 32'(exp_err));
        if (!exp_err) begin
            check_value("prdata_o", prdata_o, exp);
        end
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic push_event(input logic [7:0] id, input logic exp_fulln);
        event_fifo_valid_i = 1'b1;
        event_fifo_data_i  = id;
        @(negedge clk_i);
        event_fifo_valid_i = 1'b0;
        check_value("event_fifo_fulln_o", 32'(event_fifo_fulln_o), 32'(exp_fulln));
    endtask

    // ********************************************************
    // Write scoreboard with the service count rising by one per write
    // ********************************************************
    task automatic take_write(input fc_addr_t addr);
        exp_count = exp_count + 1;
        check_value("data_addr_o", wr_addr_q.pop_front(), addr);
        check_value("data_wdata_o", wr_data_q.pop_front(), exp_count);
    endtask

    task automatic expect_write(input fc_addr_t addr);
        int waited;
        waited = 0;
        while (wr_addr_q.size() == 0 && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (wr_addr_q.size() == 0) begin
            abort_run($sformatf("No L2 write to %h arrived in %0d cycles", addr, TIMEOUT));
        end
        take_write(addr);
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk_i);
            check_value("pending L2 writes", 32'(wr_addr_q.size()), 32'h0);
        end
    endtask

    task automatic drain_writes(input fc_addr_t addr, input int quiet);
        int idle;
        int total;
        idle  = 0;
        total = 0;
        while (idle < quiet) begin
            if (total >= 10 * TIMEOUT) begin
                abort_run($sformatf("L2 writes to %h did not stop", addr));
            end
            if (wr_addr_q.size() != 0) begin
                take_write(addr);
                idle = 0;
            end else begin
                @(negedge clk_i);
                idle++;
                total++;
            end
        end
    endtask

    // ********************************************************
    // Stimulus file reader
    // ********************************************************
    initial begin
        int               fd;
        int               code;
        logic [7:0]       cmd;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        logic [8*256-1:0] rest;
        reset_i            = 1'b1;
        fetch_en_i         = 1'b1;
        paddr_i            = '0;
        pwrite_i           = 1'b0;
        psel_i             = 1'b0;
        penable_i          = 1'b0;
        pwdata_i           = '0;
        events_i           = '0;
        event_fifo_valid_i = 1'b0;
        event_fifo_data_i  = '0;
        boot_addr_i        = BOOT_ADDR;
        exp_count          = '0;
        repeat (16) @(negedge clk_i);
        reset_i = 1'b0;
        fd = $fopen("verification/fc_subsystem_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the stimulus file");
        end
        code = $fscanf(fd, " %c", cmd);
        while (code == 1) begin
            case (cmd)
                "#": code = $fgets(rest, fd);
                "V": begin
                    code = $fscanf(fd, " %h %h", a, b);
                    // Vector of line a sits at the 256-byte aligned boot base + 4*a
                    vector_mem[{BOOT_ADDR[31:8], 8'h00} + (a << 2)] = b;
                end
                "W": begin
                    code = $fscanf(fd, " %h %h", a, b);
                    apb_write(apb_addr_t'(a), b);
                end
                "R": begin
                    code = $fscanf(fd, " %h %h %h", a, b, c);
                    apb_read(apb_addr_t'(a), b, c[0]);
                end
                "E": begin
                    code = $fscanf(fd, " %h", a);
                    events_i = a;
                    @(negedge clk_i);
                    events_i = '0;
                end
                "P": begin
                    code = $fscanf(fd, " %h %h", a, b);
                    push_event(a[7:0], b[0]);
                end
                "F": begin
                    code = $fscanf(fd, " %h", a);
                    fetch_en_i = a[0];
                    @(negedge clk_i);
                end
                "X": begin
                    code = $fscanf(fd, " %h", a);
                    expect_write(a);
                end
                "N": begin
                    code = $fscanf(fd, " %d", a);
                    expect_quiet(int'(a));
                end
                "S": begin
                    code = $fscanf(fd, " %h %d", a, b);
                    drain_writes(a, int'(b));
                end
                default: abort_run($sformatf("Unknown stimulus command %c", cmd));
            endcase
            code = $fscanf(fd, " %c", cmd);
        end
        $fclose(fd);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
